//--- Makefile
VERILATOR  ?= verilator
TOP        := scatter_tb
FILELIST   := build.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- bench/scatter_chk.sv
`timescale 1ns/10ps
`include "alloc_settings.svh"

module scatter_chk import alloc_pkg::*; (
    input logic                       clk,
    input logic                       srst,
    input logic                       en,
    input logic [`ALLOC_CONTEXTS-1:0] buf_vld,
    input ptr_t [`ALLOC_CONTEXTS-1:0] buf_ptr,
    input logic [`ALLOC_CONTEXTS-1:0] buf_take,
    input logic [`ALLOC_CONTEXTS-1:0] seg_vld,
    input seg_t [`ALLOC_CONTEXTS-1:0] seg,
    input logic [`ALLOC_CONTEXTS-1:0] seg_rdy,
    input logic                       free_vld,
    input ptr_t                       free_ptr,
    input logic                       frame_vld,
    input frame_t                     frame
);

    localparam int NC = `ALLOC_CONTEXTS;
    localparam int QD = 16;

    int                             fail_count;
    int                             since_rst;
    int                             dis_cycles;
    bit                             rst_seen;
    logic [(1<<`ALLOC_PTR_WID)-1:0] in_use;
    logic [NC-1:0]                  acc_sof;
    frame_t                         acc [NC];
    frame_t                         exp_mem [NC][QD];
    int                             wr_i [NC];
    int                             rd_i [NC];
    frame_t                         exp_frame;
    logic                           exp_ok;

    // --------------------
    // Reference model
    // --------------------
    always @(posedge clk) begin : model
        frame_t f;
        rst_seen   <= rst_seen || srst;
        since_rst  <= srst ? 0 : (since_rst < 1000 ? since_rst + 1 : since_rst);
        dis_cycles <= en ? 0 : dis_cycles + 1;
        if (srst) begin
            in_use  <= '0;
            acc_sof <= '1;
            for (int i = 0; i < NC; i++) begin
                wr_i[i] <= 0;
                rd_i[i] <= 0;
            end
        end else begin
            if (free_vld) begin
                in_use[free_ptr] <= 1'b0;
            end
            for (int i = 0; i < NC; i++) begin
                if (buf_vld[i] && buf_take[i]) begin
                    in_use[buf_ptr[i]] <= 1'b1;
                end
                if (seg_vld[i] && seg_rdy[i]) begin
                    f = acc[i];
                    if (acc_sof[i]) begin
                        f.ctxt = ctxt_t'(i);
                        f.ptr  = seg[i].ptr;
                        f.size = '0;
                        f.err  = 1'b0;
                    end
                    // Full buffer per segment and own size on the last one
                    f.size = f.size + (seg[i].eof ? frame_size_t'(seg[i].size)
                                                  : frame_size_t'(`ALLOC_BUFFER_SIZE));
                    f.err  = f.err || seg[i].err;
                    acc[i]     <= f;
                    acc_sof[i] <= seg[i].eof;
                    if (seg[i].eof) begin
                        exp_mem[i][wr_i[i] % QD] <= f;
                        wr_i[i]                  <= wr_i[i] + 1;
                    end
                end
            end
            if (frame_vld) begin
                rd_i[frame.ctxt] <= rd_i[frame.ctxt] + 1;
            end
        end
    end

    always_comb begin
        exp_frame = exp_mem[frame.ctxt][rd_i[frame.ctxt] % QD];
        exp_ok    = (wr_i[frame.ctxt] != rd_i[frame.ctxt]);
    end

    // --------------------
    // Assertions
    // --------------------
    a_quiet: assert property (@(posedge clk)
        rst_seen && (srst || since_rst < 32) |-> buf_vld == '0 && seg_rdy == '0 && !frame_vld)
        else begin
            fail_count++;
            $error("FAIL %0t: client outputs active during reset or init", $time);
        end

    a_frame: assert property (@(posedge clk) disable iff (srst)
        frame_vld |-> exp_ok && frame == exp_frame)
        else begin
            fail_count++;
            $error("FAIL %0t: completion for context %0d does not match posted frame",
                   $time, $sampled(frame.ctxt));
        end

    // Writes in flight drain within the ack latency and a few cycles
    a_en_low: assert property (@(posedge clk) disable iff (srst)
        dis_cycles > `ALLOC_MEM_WR_LATENCY + 3 |-> !frame_vld)
        else begin
            fail_count++;
            $error("FAIL %0t: completion while controller disabled", $time);
        end

    a_free: assert property (@(posedge clk) disable iff (srst)
        free_vld |-> in_use[free_ptr])
        else begin
            fail_count++;
            $error("FAIL %0t: freed pointer %0d was not in use", $time, $sampled(free_ptr));
        end

    for (genvar i = 0; i < NC; i++) begin : g_ctxt
        a_take: assert property (@(posedge clk) disable iff (srst)
            buf_vld[i] && buf_take[i] |-> !in_use[buf_ptr[i]])
            else begin
                fail_count++;
                $error("FAIL %0t: pointer %0d offered while in use", $time,
                       $sampled(buf_ptr[i]));
            end
    end

endmodule

bind scatter_top scatter_chk u_chk (.*);

//--- bench/scatter_tb.sv
`timescale 1ns/10ps
`include "alloc_settings.svh"

module scatter_tb import alloc_pkg::*; ();

    localparam int NC         = `ALLOC_CONTEXTS;
    localparam int CLK_PERIOD = 100;
    localparam int SENT_D     = 64;
    localparam int T6_FRAMES  = 6;
    // Fixed tests post 40 + 10 + 6 + 5 segments
    localparam int FIXED_SEGS = 61;

    logic          clk = 1'b0;
    logic          srst;
    logic          en;
    logic [NC-1:0] buf_vld;
    ptr_t [NC-1:0] buf_ptr;
    logic [NC-1:0] buf_take;
    logic [NC-1:0] seg_vld;
    seg_t [NC-1:0] seg;
    logic [NC-1:0] seg_rdy;
    logic          free_vld;
    ptr_t          free_ptr;
    logic          frame_vld;
    frame_t        frame;
    ptr_t          desc_rd_addr;
    desc_t         desc_rd_data;

    int     errors;
    int     tests;
    int     last_total;
    int     posted;
    int     reclaimed;
    int     wd_cycles;
    int     t6_nseg [NC][T6_FRAMES];
    seg_t   sent [NC][SENT_D];
    int     sent_wr [NC];
    int     sent_rd [NC];
    frame_t done_q [$];

    always #(CLK_PERIOD/2) clk = ~clk;

    scatter_top u_dut (
        .clk          (clk),
        .srst         (srst),
        .en           (en),
        .buf_vld      (buf_vld),
        .buf_ptr      (buf_ptr),
        .buf_take     (buf_take),
        .seg_vld      (seg_vld),
        .seg          (seg),
        .seg_rdy      (seg_rdy),
        .free_vld     (free_vld),
        .free_ptr     (free_ptr),
        .frame_vld    (frame_vld),
        .frame        (frame),
        .desc_rd_addr (desc_rd_addr),
        .desc_rd_data (desc_rd_data)
    );

    // Completions are one-cycle pulses that hold through the falling edge
    always @(negedge clk) begin
        if (frame_vld) begin
            done_q.push_back(frame);
        end
    end

    // --------------------
    // Client side
    // --------------------
    task automatic take_ptr(input int c, output ptr_t p);
        while (!buf_vld[c]) begin
            @(negedge clk);
        end
        p           = buf_ptr[c];
        buf_take[c] = 1'b1;
        @(negedge clk);
        buf_take[c] = 1'b0;
    endtask

    task automatic post_seg(input int c, input seg_t s);
        seg[c]     = s;
        seg_vld[c] = 1'b1;
        while (!seg_rdy[c]) begin
            @(negedge clk);
        end
        @(negedge clk);
        seg_vld[c] = 1'b0;
    endtask

    task automatic send_seg(input int c, input logic eof, input int size, input logic err);
        seg_t s;
        ptr_t p;
        take_ptr(c, p);
        s.ptr  = p;
        s.eof  = eof;
        s.size = seg_size_t'(size);
        s.err  = err;
        s.meta = meta_t'($urandom());
        sent[c][sent_wr[c] % SENT_D] = s;
        sent_wr[c]++;
        post_seg(c, s);
    endtask

    task automatic send_frame(input int c, input int nseg);
        for (int k = 0; k < nseg; k++) begin
            send_seg(c, k == nseg - 1,
                     (k == nseg - 1) ? int'($urandom_range(1, 64)) : `ALLOC_BUFFER_SIZE,
                     $urandom_range(0, 7) == 0);
        end
        posted++;
    endtask

    task automatic run_context(input int c);
        for (int k = 0; k < T6_FRAMES; k++) begin
            send_frame(c, t6_nseg[c][k]);
        end
    endtask

    // --------------------
    // Descriptor walk and buffer return
    // --------------------
    task automatic check_chain(input frame_t f);
        ptr_t p;
        ptr_t chain [$];
        seg_t s;
        bit   first;
        p     = f.ptr;
        first = 1'b1;
        do begin
            s = sent[f.ctxt][sent_rd[f.ctxt] % SENT_D];
            sent_rd[f.ctxt]++;
            desc_rd_addr = p;
            @(negedge clk);
            assert (p == s.ptr && desc_rd_data.sof == first && desc_rd_data.eof == s.eof &&
                    desc_rd_data.size == s.size && desc_rd_data.err == s.err &&
                    desc_rd_data.meta == s.meta)
            else begin
                errors++;
                $display("FAIL %0t: context %0d descriptor at %0d does not match segment",
                         $time, f.ctxt, p);
            end
            chain.push_back(p);
            first = 1'b0;
            p     = desc_rd_data.nxt_ptr;
        end while (!s.eof);
        while (chain.size() != 0) begin
            free_ptr = chain.pop_front();
            free_vld = 1'b1;
            @(negedge clk);
        end
        free_vld = 1'b0;
        reclaimed++;
    endtask

    initial begin : reclaim
        frame_t f;
        forever begin
            @(negedge clk);
            if (done_q.size() != 0) begin
                f = done_q.pop_front();
                check_chain(f);
            end
        end
    end

    task automatic wait_drained();
        while (reclaimed != posted) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        int total;
        total = errors + u_dut.u_chk.fail_count;
        $display("test %0d %-14s %s", tests + 1, name, total == last_total ? "ok" : "errors");
        last_total = total;
        tests++;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main
        int rand_segs;
        int total;
        void'($urandom(32'hc2f5));
        srst         = 1'b1;
        en           = 1'b1;
        buf_take     = '0;
        seg_vld      = '0;
        seg          = '0;
        free_vld     = 1'b0;
        free_ptr     = '0;
        desc_rd_addr = '0;
        rand_segs    = 0;
        for (int c = 0; c < NC; c++) begin
            for (int k = 0; k < T6_FRAMES; k++) begin
                t6_nseg[c][k] = int'($urandom_range(1, 4));
                rand_segs += t6_nseg[c][k];
            end
        end
        wd_cycles = (FIXED_SEGS + rand_segs) * 200 + 64;
        repeat (16) @(negedge clk);
        srst = 1'b0;

        while (buf_vld != '1) begin
            @(negedge clk);
        end
        end_test("reset_init");

        // More takes than the pool holds, so pointers recycle
        for (int i = 0; i < 40; i++) begin
            send_frame(i % NC, 1);
        end
        wait_drained();
        end_test("ptr_unique");

        for (int c = 0; c < NC; c++) begin
            send_frame(c, c + 1);
        end
        wait_drained();
        end_test("frame_values");

        send_frame(2, 6);
        wait_drained();
        end_test("desc_chain");

        en = 1'b0;
        repeat (8) @(negedge clk);
        // The last post ends the frame, so its completion is due only once en returns
        for (int k = 0; k < `ALLOC_SEG_Q_DEPTH + 1; k++) begin
            send_seg(0, k == `ALLOC_SEG_Q_DEPTH,
                     (k == `ALLOC_SEG_Q_DEPTH) ? 20 : `ALLOC_BUFFER_SIZE, 1'b0);
        end
        posted++;
        assert (!seg_rdy[0])
        else begin
            errors++;
            $display("FAIL %0t: seg_rdy still high with segment queue full", $time);
        end
        repeat (10) @(negedge clk);
        en = 1'b1;
        wait_drained();
        end_test("en_low");

        fork
            run_context(0);
            run_context(1);
            run_context(2);
            run_context(3);
        join
        wait_drained();
        end_test("concurrent");

        total = errors + u_dut.u_chk.fail_count;
        $display("tests %0d, checks failed %0d", tests, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", wd_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
rtl/alloc_pkg.sv
rtl/sync_fifo.sv
rtl/free_ptr_pool.sv
rtl/ctxt_frame_track.sv
rtl/desc_mem.sv
rtl/scatter_ctrl.sv
rtl/scatter_top.sv
bench/scatter_chk.sv
bench/scatter_tb.sv

//--- include/alloc_settings.svh
`ifndef ALLOC_SETTINGS_SVH
`define ALLOC_SETTINGS_SVH

// Contexts sharing the store path
`define ALLOC_CONTEXTS 4

// Buffer pool, 32 buffers of 64 bytes
`define ALLOC_PTR_WID 5
`define ALLOC_BUFFER_SIZE 64
`define ALLOC_MAX_FRAME_SIZE 2048

`define ALLOC_META_WID 4

// Queue depths
`define ALLOC_SEG_Q_DEPTH 4
`define ALLOC_PREFETCH_DEPTH 2

// Descriptor memory write acknowledge latency, in cycles
`define ALLOC_MEM_WR_LATENCY 3

`endif

//--- rtl/alloc_pkg.sv
`include "alloc_settings.svh"

package alloc_pkg;

    typedef logic [`ALLOC_PTR_WID-1:0]                      ptr_t;
    // Wide enough to hold a full buffer
    typedef logic [$clog2(`ALLOC_BUFFER_SIZE+1)-1:0]        seg_size_t;
    typedef logic [$clog2(`ALLOC_MAX_FRAME_SIZE+1)-1:0]     frame_size_t;
    typedef logic [$clog2(`ALLOC_CONTEXTS)-1:0]             ctxt_t;
    typedef logic [`ALLOC_META_WID-1:0]                     meta_t;

    // Segment record posted by a client
    typedef struct packed {
        ptr_t      ptr;
        logic      eof;
        seg_size_t size;
        logic      err;
        meta_t     meta;
    } seg_t;

    // Linked-list descriptor, stored at the segment's own pointer
    typedef struct packed {
        logic      sof;
        logic      eof;
        ptr_t      nxt_ptr;
        seg_size_t size;
        logic      err;
        meta_t     meta;
    } desc_t;

    typedef struct packed {
        ctxt_t       ctxt;
        ptr_t        ptr;
        frame_size_t size;
        logic        err;
    } frame_t;

    typedef enum logic [1:0] {
        RESET,
        DISABLED,
        IDLE,
        WRITE
    } ctrl_state_t;

endpackage

//--- rtl/ctxt_frame_track.sv
`timescale 1ns/10ps
`include "alloc_settings.svh"

module ctxt_frame_track import alloc_pkg::*; (
    input  logic        clk,
    input  logic        srst,
    // Pool side
    input  logic        pool_vld,
    input  logic        pool_sel_me,
    input  ptr_t        pool_ptr,
    output logic        pool_take,
    // Pointer offer to the client
    output logic        buf_vld,
    output ptr_t        buf_ptr,
    input  logic        buf_take,
    // Segment post from the client
    input  logic        seg_vld,
    input  seg_t        seg,
    output logic        seg_rdy,
    // Controller side
    output logic        desc_vld,
    output desc_t       desc,
    output ptr_t        desc_addr,
    input  logic        wr_done,
    // Frame state
    output ptr_t        frame_ptr,
    output frame_size_t frame_size,
    output logic        frame_err
);

    logic                  pf_wr_rdy;
    logic                  live;
    logic                  post_sof;
    logic                  sq_wr_rdy;
    logic                  sq_rd;
    logic                  sq_vld;
    logic [$bits(seg_t):0] sq_data;
    seg_t                  nxt_seg;
    logic                  peek_vld;
    logic                  peek_sof;
    seg_t                  peek;

    // --------------------
    // Pointer prefetch
    // --------------------
    assign pool_take = pool_vld && pool_sel_me && pf_wr_rdy;

    sync_fifo #(
        .WIDTH ($bits(ptr_t)),
        .DEPTH (`ALLOC_PREFETCH_DEPTH)
    ) u_prefetch_q (
        .clk     (clk),
        .srst    (srst),
        .wr      (pool_take),
        .wr_rdy  (pf_wr_rdy),
        .wr_data (pool_ptr),
        .rd      (buf_take),
        .rd_vld  (buf_vld),
        .rd_data (buf_ptr)
    );

    // Posting opens once the pool has come up
    always_ff @(posedge clk) begin
        if (srst) begin
            live <= 1'b0;
        end else if (pool_vld) begin
            live <= 1'b1;
        end
    end

    assign seg_rdy = live && sq_wr_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            post_sof <= 1'b1;
        end else if (seg_vld && seg_rdy) begin
            post_sof <= seg.eof;
        end
    end

    // --------------------
    // Segment queue and peek
    // --------------------
    sync_fifo #(
        .WIDTH ($bits(seg_t) + 1),
        .DEPTH (`ALLOC_SEG_Q_DEPTH)
    ) u_seg_q (
        .clk     (clk),
        .srst    (srst),
        .wr      (seg_vld && live),
        .wr_rdy  (sq_wr_rdy),
        .wr_data ({post_sof, seg}),
        .rd      (sq_rd),
        .rd_vld  (sq_vld),
        .rd_data (sq_data)
    );

    assign nxt_seg = sq_data[$bits(seg_t)-1:0];

    // Head segment moves to peek so that its successor's pointer shows
    assign sq_rd = !peek_vld || wr_done;

    always_ff @(posedge clk) begin
        if (srst) begin
            peek_vld <= 1'b0;
        end else if (sq_rd) begin
            peek_vld <= sq_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (sq_rd) begin
            peek_sof <= sq_data[$bits(seg_t)];
            peek     <= nxt_seg;
        end
    end

    assign desc_vld     = peek_vld && (peek.eof || sq_vld);
    assign desc_addr    = peek.ptr;
    assign desc.sof     = peek_sof;
    assign desc.eof     = peek.eof;
    assign desc.nxt_ptr = nxt_seg.ptr;
    assign desc.size    = peek.size;
    assign desc.err     = peek.err;
    assign desc.meta    = peek.meta;

    // --------------------
    // Frame accumulators
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_done && peek_sof) begin
            frame_ptr <= peek.ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            frame_size <= '0;
            frame_err  <= 1'b0;
        end else if (wr_done) begin
            // Full buffer per segment, own size at end of frame
            frame_size <= (peek_sof ? '0 : frame_size) +
                          (peek.eof ? frame_size_t'(peek.size)
                                    : frame_size_t'(`ALLOC_BUFFER_SIZE));
            frame_err  <= peek.err || (!peek_sof && frame_err);
        end
    end

endmodule

//--- rtl/desc_mem.sv
`timescale 1ns/10ps
`include "alloc_settings.svh"

module desc_mem import alloc_pkg::*; (
    input  logic  clk,
    input  logic  srst,
    input  logic  wr_req,
    output logic  wr_rdy,
    input  ptr_t  wr_addr,
    input  desc_t wr_data,
    output logic  wr_ack,
    input  ptr_t  rd_addr,
    output desc_t rd_data,
    output logic  init_done
);

    localparam int NUM_ENTRIES = 1 << `ALLOC_PTR_WID;
    localparam int LAT         = `ALLOC_MEM_WR_LATENCY;

    desc_t          mem [NUM_ENTRIES];
    ptr_t           init_addr;
    logic           accept;
    logic [LAT-1:0] ack_sr;

    // Clear walk over every entry
    always_ff @(posedge clk) begin
        if (srst) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_addr <= init_addr + 1'b1;
            if (init_addr == ptr_t'(NUM_ENTRIES-1)) begin
                init_done <= 1'b1;
            end
        end
    end

    assign wr_rdy = init_done;
    assign accept = wr_req && wr_rdy;

    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_addr] <= '0;
        end else if (accept) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Acknowledge delay line
    always_ff @(posedge clk) begin
        if (srst) begin
            ack_sr <= '0;
        end else begin
            ack_sr <= {ack_sr[LAT-2:0], accept};
        end
    end

    assign wr_ack = ack_sr[LAT-1];

endmodule

//--- rtl/free_ptr_pool.sv
`timescale 1ns/10ps
`include "alloc_settings.svh"

module free_ptr_pool import alloc_pkg::*; (
    input  logic  clk,
    input  logic  srst,
    output logic  ptr_vld,
    output ptr_t  ptr,
    input  logic  ptr_take,
    output ctxt_t sel,
    input  logic  free_vld,
    input  ptr_t  free_ptr,
    output logic  init_done
);

    localparam int NUM_PTRS = 1 << `ALLOC_PTR_WID;

    ptr_t init_ptr;
    logic fl_wr;
    ptr_t fl_wr_data;
    logic fl_vld;

    // --------------------
    // Free list fill
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            init_ptr  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_ptr <= init_ptr + 1'b1;
            if (init_ptr == ptr_t'(NUM_PTRS-1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // Init pushes every pointer once, then returned ones
    assign fl_wr      = !init_done || free_vld;
    assign fl_wr_data = init_done ? free_ptr : init_ptr;

    // Deep enough for the whole pool, so a free is never refused
    sync_fifo #(
        .WIDTH ($bits(ptr_t)),
        .DEPTH (NUM_PTRS)
    ) u_free_list (
        .clk     (clk),
        .srst    (srst),
        .wr      (fl_wr),
        .wr_rdy  (),
        .wr_data (fl_wr_data),
        .rd      (ptr_take),
        .rd_vld  (fl_vld),
        .rd_data (ptr)
    );

    assign ptr_vld = fl_vld && init_done;

    // Prefetch turn, moves on every cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            sel <= '0;
        end else begin
            sel <= (sel == ctxt_t'(`ALLOC_CONTEXTS-1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

//--- rtl/scatter_ctrl.sv
`timescale 1ns/10ps
`include "alloc_settings.svh"

module scatter_ctrl import alloc_pkg::*; (
    input  logic                                  clk,
    input  logic                                  srst,
    input  logic                                  en,
    input  logic                                  init_done,
    // Trackers
    input  logic [`ALLOC_CONTEXTS-1:0]            desc_vld,
    input  desc_t [`ALLOC_CONTEXTS-1:0]           desc,
    input  ptr_t [`ALLOC_CONTEXTS-1:0]            desc_addr,
    input  ptr_t [`ALLOC_CONTEXTS-1:0]            frame_ptr,
    input  frame_size_t [`ALLOC_CONTEXTS-1:0]     frame_size,
    input  logic [`ALLOC_CONTEXTS-1:0]            frame_err,
    output logic [`ALLOC_CONTEXTS-1:0]            wr_done,
    // Descriptor memory
    output logic                                  wr_req,
    input  logic                                  wr_rdy,
    output ptr_t                                  wr_addr,
    output desc_t                                 wr_data,
    input  logic                                  wr_ack,
    // Completion
    output logic                                  frame_vld,
    output frame_t                                frame
);

    localparam int NC = `ALLOC_CONTEXTS;

    ctrl_state_t             state;
    ctrl_state_t             nxt_state;
    logic                    grant;
    ctxt_t                   gnt;
    ctxt_t                   prio;
    ctxt_t                   sel_r;
    logic                    wc_in_vld;
    frame_t                  wc_in;
    logic                    ack_r;
    logic                    wc_vld;
    logic [$bits(frame_t):0] wc_out;

    // --------------------
    // Store FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        grant     = 1'b0;
        wr_req    = 1'b0;
        case (state)
            RESET: begin
                if (init_done) begin
                    nxt_state = en ? IDLE : DISABLED;
                end
            end
            DISABLED: begin
                if (en) begin
                    nxt_state = IDLE;
                end
            end
            IDLE: begin
                if (!en) begin
                    nxt_state = DISABLED;
                end else if (|desc_vld) begin
                    grant     = 1'b1;
                    nxt_state = WRITE;
                end
            end
            WRITE: begin
                wr_req = 1'b1;
                if (wr_rdy) begin
                    nxt_state = IDLE;
                end
            end
            default: nxt_state = RESET;
        endcase
    end

    // Round robin, first requester at or after prio
    always_comb begin : rr_pick
        int k;
        gnt = prio;
        for (int i = NC-1; i >= 0; i--) begin
            k = (int'(prio) + i) % NC;
            if (desc_vld[k]) begin
                gnt = ctxt_t'(k);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            prio <= '0;
        end else if (grant) begin
            prio <= (gnt == ctxt_t'(NC-1)) ? '0 : gnt + 1'b1;
        end
    end

    // Latch granted descriptor and context
    always_ff @(posedge clk) begin
        if (grant) begin
            sel_r   <= gnt;
            wr_addr <= desc_addr[gnt];
            wr_data <= desc[gnt];
        end
    end

    always_comb begin
        for (int i = 0; i < NC; i++) begin
            wr_done[i] = wr_req && wr_rdy && (sel_r == ctxt_t'(i));
        end
    end

    // --------------------
    // Write context and completion
    // --------------------
    // Accumulators have taken the accepted segment by the next cycle
    assign wc_in.ctxt = sel_r;
    assign wc_in.ptr  = frame_ptr[sel_r];
    assign wc_in.size = frame_size[sel_r];
    assign wc_in.err  = frame_err[sel_r];

    always_ff @(posedge clk) begin
        if (srst) begin
            wc_in_vld <= 1'b0;
            ack_r     <= 1'b0;
        end else begin
            wc_in_vld <= wr_req && wr_rdy;
            ack_r     <= wr_ack;
        end
    end

    sync_fifo #(
        .WIDTH ($bits(frame_t) + 1),
        .DEPTH (`ALLOC_MEM_WR_LATENCY)
    ) u_wr_ctxt_q (
        .clk     (clk),
        .srst    (srst),
        .wr      (wc_in_vld),
        .wr_rdy  (),
        .wr_data ({wr_data.eof, wc_in}),
        .rd      (ack_r),
        .rd_vld  (wc_vld),
        .rd_data (wc_out)
    );

    assign frame     = wc_out[$bits(frame_t)-1:0];
    assign frame_vld = ack_r && wc_vld && wc_out[$bits(frame_t)];

endmodule

//--- rtl/scatter_top.sv
`timescale 1ns/10ps
`include "alloc_settings.svh"

module scatter_top import alloc_pkg::*; (
    input  logic                              clk,
    input  logic                              srst,
    input  logic                              en,
    // Per-context client ports
    output logic [`ALLOC_CONTEXTS-1:0]        buf_vld,
    output ptr_t [`ALLOC_CONTEXTS-1:0]        buf_ptr,
    input  logic [`ALLOC_CONTEXTS-1:0]        buf_take,
    input  logic [`ALLOC_CONTEXTS-1:0]        seg_vld,
    input  seg_t [`ALLOC_CONTEXTS-1:0]        seg,
    output logic [`ALLOC_CONTEXTS-1:0]        seg_rdy,
    // Buffer return
    input  logic                              free_vld,
    input  ptr_t                              free_ptr,
    // Completion
    output logic                              frame_vld,
    output frame_t                            frame,
    // Descriptor read
    input  ptr_t                              desc_rd_addr,
    output desc_t                             desc_rd_data
);

    localparam int NC = `ALLOC_CONTEXTS;

    logic                     pool_vld;
    ptr_t                     pool_ptr;
    ctxt_t                    pool_sel;
    logic [NC-1:0]            pool_take;
    logic                     pool_init_done;
    logic                     mem_init_done;
    logic [NC-1:0]            desc_vld;
    desc_t [NC-1:0]           desc;
    ptr_t [NC-1:0]            desc_addr;
    ptr_t [NC-1:0]            frame_ptr;
    frame_size_t [NC-1:0]     frame_size;
    logic [NC-1:0]            frame_err;
    logic [NC-1:0]            wr_done;
    logic                     wr_req;
    logic                     wr_rdy;
    ptr_t                     wr_addr;
    desc_t                    wr_data;
    logic                     wr_ack;

    free_ptr_pool u_pool (
        .clk       (clk),
        .srst      (srst),
        .ptr_vld   (pool_vld),
        .ptr       (pool_ptr),
        .ptr_take  (|pool_take),
        .sel       (pool_sel),
        .free_vld  (free_vld),
        .free_ptr  (free_ptr),
        .init_done (pool_init_done)
    );

    for (genvar i = 0; i < NC; i++) begin : g_ctxt
        ctxt_frame_track u_track (
            .clk         (clk),
            .srst        (srst),
            .pool_vld    (pool_vld),
            .pool_sel_me (pool_sel == ctxt_t'(i)),
            .pool_ptr    (pool_ptr),
            .pool_take   (pool_take[i]),
            .buf_vld     (buf_vld[i]),
            .buf_ptr     (buf_ptr[i]),
            .buf_take    (buf_take[i]),
            .seg_vld     (seg_vld[i]),
            .seg         (seg[i]),
            .seg_rdy     (seg_rdy[i]),
            .desc_vld    (desc_vld[i]),
            .desc        (desc[i]),
            .desc_addr   (desc_addr[i]),
            .wr_done     (wr_done[i]),
            .frame_ptr   (frame_ptr[i]),
            .frame_size  (frame_size[i]),
            .frame_err   (frame_err[i])
        );
    end

    // Writes wait for both the pool and the memory to come up
    scatter_ctrl u_ctrl (
        .clk        (clk),
        .srst       (srst),
        .en         (en),
        .init_done  (pool_init_done && mem_init_done),
        .desc_vld   (desc_vld),
        .desc       (desc),
        .desc_addr  (desc_addr),
        .frame_ptr  (frame_ptr),
        .frame_size (frame_size),
        .frame_err  (frame_err),
        .wr_done    (wr_done),
        .wr_req     (wr_req),
        .wr_rdy     (wr_rdy),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_ack     (wr_ack),
        .frame_vld  (frame_vld),
        .frame      (frame)
    );

    desc_mem u_mem (
        .clk       (clk),
        .srst      (srst),
        .wr_req    (wr_req),
        .wr_rdy    (wr_rdy),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_ack    (wr_ack),
        .rd_addr   (desc_rd_addr),
        .rd_data   (desc_rd_data),
        .init_done (mem_init_done)
    );

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             srst,
    input  logic             wr,
    output logic             wr_rdy,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd,
    output logic             rd_vld,
    output logic [WIDTH-1:0] rd_data
);

    localparam int AW = DEPTH > 1 ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH+1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign wr_rdy = (count != CW'(DEPTH));
    assign rd_vld = (count != '0);

    // Requests without room or data are dropped
    assign do_wr = wr && wr_rdy;
    assign do_rd = rd && rd_vld;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_wr) - CW'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head is visible before the read
    assign rd_data = mem[rd_ptr];

endmodule
